// ==== source/backend_pkg.sv ====
// backend shared definitions
// width typedefs and load/store size codes for the memory and
// writeback stages of the rv32 back end.

`default_nettype none

package backend_pkg;

    // ##################################################
    // widths
    // ##################################################

    typedef logic [31:0] word_t;     // data word, pc or address.
    typedef logic [4:0]  reg_idx_t;  // integer register index.
    typedef logic [3:0]  csr_we_t;   // one-hot csr write enables.
    typedef logic [1:0]  csr_idx_t;  // csr read index.
    typedef logic [2:0]  mem_size_t; // funct3 size code.

    // ##################################################
    // load/store size codes, funct3 encoding
    // ##################################################

    localparam mem_size_t size_byte  = 3'd0;
    localparam mem_size_t size_half  = 3'd1;
    localparam mem_size_t size_word  = 3'd2;
    localparam mem_size_t size_byteu = 3'd4; // zero-extended byte.
    localparam mem_size_t size_halfu = 3'd5; // zero-extended half.

endpackage

`default_nettype wire

// ==== source/data_ram.sv ====
// data ram
// word-organised local memory, combinational read and
// byte-enabled write on the rising clock edge.

`timescale 1ns/100ps
`default_nettype none

module data_ram import backend_pkg::*; #(
    parameter int ram_words = 256
) (
    input  wire        clk,
    input  wire word_t addr,   // word address, already masked.
    input  wire [3:0]  we,     // byte strobes.
    input  wire word_t wdata,
    output word_t      rdata
);

    localparam int aw = $clog2(ram_words);

    word_t          mem [ram_words];
    logic  [aw-1:0] word_sel;

    assign word_sel = addr[aw-1:0];

    // one lane per strobe.
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[word_sel][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

    assign rdata = mem[word_sel]; // async read.

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
// memory stage
// ex/mem register, store lane alignment and load extraction on the
// data ram, plus the csr read request for the instruction in flight.

`timescale 1ns/100ps
`default_nettype none

module mem_stage import backend_pkg::*; #(
    parameter int ram_words = 256
) (
    input  wire            clk,
    input  wire            rst_n,

    input  wire word_t     ex_result,
    input  wire word_t     store_data,
    input  wire word_t     pc,
    input  wire reg_idx_t  rd,
    input  wire            r_wen,
    input  wire            mem_ren,
    input  wire            mem_wen,
    input  wire            jump_flag,
    input  wire            branch_flag,
    input  wire mem_size_t mem_size,
    input  wire csr_idx_t  csr_idx,
    input  wire csr_we_t   csr_wen,

    output word_t          ram_addr,
    output logic [3:0]     ram_we,
    output word_t          ram_wdata,
    input  wire word_t     ram_rdata,

    output csr_idx_t       csr_raddr,
    input  wire word_t     csr_rdata,

    output word_t          mem_rdata,
    output word_t          ex_result_q,
    output word_t          csrs,
    output word_t          pc_q,
    output reg_idx_t       rd_q,
    output csr_we_t        csr_wen_q,
    output logic           r_wen_q,
    output logic           mem_ren_q,
    output logic           jump_flag_q,
    output logic           branch_flag_q
);

    localparam word_t addr_mask = word_t'(ram_words - 1);

    word_t      store_data_q;
    mem_size_t  mem_size_q;
    csr_idx_t   csr_idx_q;
    logic       mem_wen_q;
    logic [1:0] byte_off;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;

    // ##################################################
    // ex/mem register
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_result_q   <= '0;
            store_data_q  <= '0;
            pc_q          <= '0;
            rd_q          <= '0;
            mem_size_q    <= size_byte;
            csr_idx_q     <= '0;
            csr_wen_q     <= '0;
            r_wen_q       <= 1'b0;
            mem_ren_q     <= 1'b0;
            mem_wen_q     <= 1'b0;
            jump_flag_q   <= 1'b0;
            branch_flag_q <= 1'b0;
        end else begin
            ex_result_q   <= ex_result;
            store_data_q  <= store_data;
            pc_q          <= pc;
            rd_q          <= rd;
            mem_size_q    <= mem_size;
            csr_idx_q     <= csr_idx;
            csr_wen_q     <= csr_wen;
            r_wen_q       <= r_wen;
            mem_ren_q     <= mem_ren;
            mem_wen_q     <= mem_wen;
            jump_flag_q   <= jump_flag;
            branch_flag_q <= branch_flag;
        end
    end

    assign byte_off = ex_result_q[1:0];
    assign ram_addr = (ex_result_q >> 2) & addr_mask; // byte to word address.

    // ##################################################
    // store alignment
    // ##################################################

    always_comb begin
        ram_we    = 4'b1111;
        ram_wdata = store_data_q;
        case (mem_size_q[1:0]) // unsigned codes share the store width.
            size_byte[1:0]: begin
                ram_we    = 4'b0001 << byte_off;
                ram_wdata = {4{store_data_q[7:0]}};
            end
            size_half[1:0]: begin
                ram_we    = byte_off[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{store_data_q[15:0]}};
            end
            default: ;
        endcase
        if (!mem_wen_q) begin
            ram_we = 4'b0000;
        end
    end

    // ##################################################
    // load extraction
    // ##################################################

    always_comb begin
        case (byte_off)
            2'd0:    ld_byte = ram_rdata[7:0];
            2'd1:    ld_byte = ram_rdata[15:8];
            2'd2:    ld_byte = ram_rdata[23:16];
            default: ld_byte = ram_rdata[31:24];
        endcase
    end

    assign ld_half = byte_off[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (mem_size_q)
            size_byte:  mem_rdata = {{24{ld_byte[7]}}, ld_byte};
            size_half:  mem_rdata = {{16{ld_half[15]}}, ld_half};
            size_byteu: mem_rdata = {24'd0, ld_byte};
            size_halfu: mem_rdata = {16'd0, ld_half};
            default:    mem_rdata = ram_rdata; // word.
        endcase
    end

    assign csr_raddr = csr_idx_q;
    assign csrs      = csr_rdata; // old csr value, bypassed in csr_file.

endmodule

`default_nettype wire

// ==== source/wb_unit.sv ====
// writeback unit
// mem/wb register and selection of the value written to rd,
// plus the retire record and the new csr value.

`timescale 1ns/100ps
`default_nettype none

module wb_unit import backend_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,

    input  wire word_t    mem_rdata,
    input  wire word_t    ex_result,
    input  wire word_t    csrs,
    input  wire word_t    pc,
    input  wire reg_idx_t rd,
    input  wire csr_we_t  csr_wen,
    input  wire           r_wen,
    input  wire           mem_ren,
    input  wire           jump_flag,
    input  wire           branch_flag,

    output word_t         pc_next,
    output word_t         csrd,
    output word_t         rd_value,
    output reg_idx_t      rd_next,
    output csr_we_t       csr_wen_next,
    output logic          r_wen_next,
    output logic          branch_flag_next
);

    word_t mem_rdata_q;
    word_t ex_result_q;
    word_t csrs_q;
    logic  mem_ren_q;
    logic  jump_flag_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rdata_q      <= '0;
            ex_result_q      <= '0;
            csrs_q           <= '0;
            pc_next          <= '0;
            rd_next          <= '0;
            csr_wen_next     <= '0;
            r_wen_next       <= 1'b0;
            mem_ren_q        <= 1'b0;
            jump_flag_q      <= 1'b0;
            branch_flag_next <= 1'b0;
        end else begin
            mem_rdata_q      <= mem_rdata;
            ex_result_q      <= ex_result;
            csrs_q           <= csrs;
            pc_next          <= pc;
            rd_next          <= rd;
            csr_wen_next     <= csr_wen;
            r_wen_next       <= r_wen;
            mem_ren_q        <= mem_ren;
            jump_flag_q      <= jump_flag;
            branch_flag_next <= branch_flag;
        end
    end

    // link address, then load, then old csr, then alu result.
    assign rd_value = jump_flag_q        ? pc_next + 32'd4 :
                      mem_ren_q          ? mem_rdata_q :
                      (csr_wen_next != '0) ? csrs_q :
                                           ex_result_q;

    assign csrd = ex_result_q; // new csr value.

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// integer register file
// 31 writable registers, x0 hardwired to zero, one write port
// and two combinational read ports.

`timescale 1ns/100ps
`default_nettype none

module reg_file import backend_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           we,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata,
    input  wire reg_idx_t raddr,
    output word_t         rdata,
    input  wire reg_idx_t dbg_raddr,
    output word_t         dbg_rdata
);

    word_t regs [1:31];

    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        val = '0;
        if (idx != '0) begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // x0 writes dropped.
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata     = read_reg(raddr);     // no write bypass.
        dbg_rdata = read_reg(dbg_raddr);
    end

endmodule

`default_nettype wire

// ==== source/csr_file.sv ====
// csr file
// four 32-bit control registers with one-hot write enables.
// a read of the register being written returns the new value.

`timescale 1ns/100ps
`default_nettype none

module csr_file import backend_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire csr_we_t  wen,
    input  wire word_t    wdata,
    input  wire csr_idx_t raddr,
    output word_t         rdata
);

    word_t csr_q [4];

    // ##################################################
    // write
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    csr_q[i] <= wdata;
                end
            end
        end
    end

    // ##################################################
    // read with bypass
    // ##################################################

    // write in wb belongs to the instruction just ahead of the reader.
    always_comb begin
        if (wen[raddr]) begin
            rdata = wdata;
        end else begin
            rdata = csr_q[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== source/backend_top.sv ====
// rv32 back end
// memory stage, writeback unit, data ram, register file and
// csr file wired together behind the execute-stage inputs.

`timescale 1ns/100ps
`default_nettype none

module backend_top import backend_pkg::*; #(
    parameter int ram_words = 256
) (
    input  wire            clk,
    input  wire            rst_n,

    input  wire word_t     ex_result,
    input  wire word_t     store_data,
    input  wire word_t     pc,
    input  wire reg_idx_t  rd,
    input  wire            r_wen,
    input  wire            mem_ren,
    input  wire            mem_wen,
    input  wire mem_size_t mem_size,
    input  wire            jump_flag,
    input  wire            branch_flag,
    input  wire csr_idx_t  csr_idx,
    input  wire csr_we_t   csr_wen,

    input  wire reg_idx_t  rs_addr,
    output word_t          rs_data,
    input  wire reg_idx_t  dbg_raddr,
    output word_t          dbg_rdata,

    output logic           wb_we,
    output reg_idx_t       wb_rd,
    output word_t          wb_value,
    output word_t          retire_pc,
    output logic           retire_branch
);

    // ##################################################
    // stage wiring
    // ##################################################

    word_t    ram_addr;
    logic [3:0] ram_we;
    word_t    ram_wdata;
    word_t    ram_rdata;
    csr_idx_t csr_raddr;
    word_t    csr_rdata;
    word_t    mem_rdata;
    word_t    m_ex_result;
    word_t    m_csrs;
    word_t    m_pc;
    reg_idx_t m_rd;
    csr_we_t  m_csr_wen;
    logic     m_r_wen;
    logic     m_mem_ren;
    logic     m_jump_flag;
    logic     m_branch_flag;
    word_t    csrd;
    csr_we_t  csr_wen_next;

    mem_stage #(.ram_words(ram_words)) i_mem_stage (
        .clk(clk), .rst_n(rst_n),
        .ex_result(ex_result), .store_data(store_data), .pc(pc), .rd(rd),
        .r_wen(r_wen), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .jump_flag(jump_flag), .branch_flag(branch_flag), .mem_size(mem_size),
        .csr_idx(csr_idx), .csr_wen(csr_wen),
        .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata), .csr_raddr(csr_raddr), .csr_rdata(csr_rdata),
        .mem_rdata(mem_rdata), .ex_result_q(m_ex_result), .csrs(m_csrs),
        .pc_q(m_pc), .rd_q(m_rd), .csr_wen_q(m_csr_wen), .r_wen_q(m_r_wen),
        .mem_ren_q(m_mem_ren), .jump_flag_q(m_jump_flag),
        .branch_flag_q(m_branch_flag)
    );

    data_ram #(.ram_words(ram_words)) i_data_ram (
        .clk(clk), .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    wb_unit i_wb_unit (
        .clk(clk), .rst_n(rst_n),
        .mem_rdata(mem_rdata), .ex_result(m_ex_result), .csrs(m_csrs), .pc(m_pc),
        .rd(m_rd), .csr_wen(m_csr_wen), .r_wen(m_r_wen), .mem_ren(m_mem_ren),
        .jump_flag(m_jump_flag), .branch_flag(m_branch_flag),
        .pc_next(retire_pc), .csrd(csrd), .rd_value(wb_value), .rd_next(wb_rd),
        .csr_wen_next(csr_wen_next), .r_wen_next(wb_we),
        .branch_flag_next(retire_branch)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .we(wb_we), .waddr(wb_rd), .wdata(wb_value),
        .raddr(rs_addr), .rdata(rs_data),
        .dbg_raddr(dbg_raddr), .dbg_rdata(dbg_rdata)
    );

    csr_file i_csr_file (
        .clk(clk), .rst_n(rst_n),
        .wen(csr_wen_next), .wdata(csrd), .raddr(csr_raddr), .rdata(csr_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/backend_tb.sv ====
// back end testbench
// feeds executed instructions into the rv32 back end and checks the
// writeback tap, retire record and register reads against a model.

`timescale 1ns/100ps
`default_nettype none

module backend_tb import backend_pkg::*; ();

    localparam int ram_words  = 256;
    localparam int aw         = $clog2(ram_words);
    localparam int len_regs   = 35; // drain plus one register per cycle.
    localparam int len_direct = 2 + ram_words + 7 + 19 + 4 + 9;
    localparam int len_random = 400;
    localparam int max_cycles = len_direct + 6 * len_regs + len_random + 50;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    value;
        word_t    pc;
        logic     branch;
    } exp_t;

    logic      clk;
    logic      rst_n;
    word_t     ex_result, store_data, pc, rs_data, dbg_rdata, wb_value, retire_pc;
    reg_idx_t  rd, rs_addr, dbg_raddr, wb_rd;
    logic      r_wen, mem_ren, mem_wen, jump_flag, branch_flag, wb_we, retire_branch;
    mem_size_t mem_size;
    csr_idx_t  csr_idx;
    csr_we_t   csr_wen;

    word_t m_regs [32];
    word_t m_csr  [4];
    word_t m_ram  [ram_words];
    exp_t  exp_q  [$];
    exp_t  cur_exp;
    exp_t  head;
    word_t pc_ctr;
    int    seed;
    int    tap_errors = 0;
    int    reg_errors = 0;
    int    cycles = 0;

    backend_top #(.ram_words(ram_words)) i_backend_top (
        .clk(clk), .rst_n(rst_n),
        .ex_result(ex_result), .store_data(store_data), .pc(pc), .rd(rd),
        .r_wen(r_wen), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_size(mem_size),
        .jump_flag(jump_flag), .branch_flag(branch_flag),
        .csr_idx(csr_idx), .csr_wen(csr_wen),
        .rs_addr(rs_addr), .rs_data(rs_data), .dbg_raddr(dbg_raddr), .dbg_rdata(dbg_rdata),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value),
        .retire_pc(retire_pc), .retire_branch(retire_branch)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ##################################################
    // compare tasks
    // ##################################################

    task automatic check_word(input string name, input word_t got, input word_t want,
                              inout int errs);
        if (got !== want) begin
            errs++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t want,
                             inout int errs);
        if (got !== want) begin
            errs++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want,
                             inout int errs);
        if (got !== want) begin
            errs++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // ##################################################
    // reference model
    // ##################################################

    function automatic word_t load_extract(input word_t w, input logic [1:0] off,
                                           input mem_size_t sz);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> {off, 3'b000});
        h = 16'(w >> {off[1], 4'b0000});
        case (sz)
            size_byte:  return {{24{b[7]}}, b};
            size_half:  return {{16{h[15]}}, h};
            size_byteu: return {24'd0, b};
            size_halfu: return {16'd0, h};
            default:    return w;
        endcase
    endfunction

    function automatic word_t store_merge(input word_t old, input word_t data,
                                          input logic [1:0] off, input mem_size_t sz);
        word_t      mask;
        logic [4:0] sh;
        mask = 32'hffff_ffff; // word.
        sh   = 5'd0;
        if (sz == size_byte || sz == size_byteu) begin
            mask = 32'h0000_00ff;
            sh   = {off, 3'b000};
        end else if (sz == size_half || sz == size_halfu) begin
            mask = 32'h0000_ffff;
            sh   = {off[1], 4'b0000};
        end
        return (old & ~(mask << sh)) | ((data & mask) << sh);
    endfunction

    // link address, load, old csr, alu result.
    function automatic word_t wb_select(input logic jf, input word_t pcv, input logic mr,
                                        input word_t ld, input csr_we_t cw,
                                        input word_t old_csr, input word_t exr);
        if (jf) return pcv + 32'd4;
        if (mr) return ld;
        if (cw != '0) return old_csr;
        return exr;
    endfunction

    // ##################################################
    // stimulus
    // ##################################################

    task automatic issue(input word_t exr, input word_t sd, input reg_idx_t rdv,
                         input logic rw, input logic mr, input logic mw, input mem_size_t sz,
                         input logic jf, input logic bf, input csr_idx_t ci, input csr_we_t cw);
        logic [aw-1:0] idx;
        word_t         value;
        @(posedge clk);
        #1;
        ex_result   = exr;
        store_data  = sd;
        pc          = pc_ctr;
        rd          = rdv;
        r_wen       = rw;
        mem_ren     = mr;
        mem_wen     = mw;
        mem_size    = sz;
        jump_flag   = jf;
        branch_flag = bf;
        csr_idx     = ci;
        csr_wen     = cw;
        idx   = exr[aw+1:2];
        value = wb_select(jf, pc_ctr, mr, load_extract(m_ram[idx], exr[1:0], sz),
                          cw, m_csr[ci], exr);
        if (mw) m_ram[idx] = store_merge(m_ram[idx], sd, exr[1:0], sz);
        for (int i = 0; i < 4; i++) begin
            if (cw[i]) m_csr[i] = exr;
        end
        if (rw && rdv != '0) m_regs[rdv] = value;
        cur_exp = '{rw, rdv, value, pc_ctr, bf};
        pc_ctr  = pc_ctr + 32'd4;
    endtask

    task automatic bubble();
        issue('0, '0, '0, 1'b0, 1'b0, 1'b0, size_byte, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic alu(input reg_idx_t rdv, input word_t v);
        issue(v, '0, rdv, 1'b1, 1'b0, 1'b0, size_word, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic store(input word_t addr, input word_t data, input mem_size_t sz);
        issue(addr, data, '0, 1'b0, 1'b0, 1'b1, sz, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic load(input reg_idx_t rdv, input word_t addr, input mem_size_t sz);
        issue(addr, '0, rdv, 1'b1, 1'b1, 1'b0, sz, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic csr_access(input reg_idx_t rdv, input csr_idx_t ci, input word_t v);
        issue(v, '0, rdv, 1'b1, 1'b0, 1'b0, size_word, 1'b0, 1'b0, ci, csr_we_t'(1 << ci));
    endtask

    task automatic random_instr();
        word_t     r;
        word_t     v;
        word_t     d;
        mem_size_t sz;
        r  = $random(seed);
        v  = $random(seed);
        d  = $random(seed);
        sz = r[2:0];
        if (sz == 3'd3 || sz > size_halfu) sz = size_word;
        if (sz[1:0] == 2'd1) v[0] = 1'b0;   // aligned halves.
        if (sz == size_word) v[1:0] = 2'b00;
        case (r[31:29])
            3'd2:    load(r[12:8], v, sz);
            3'd3:    store(v, d, sz);
            3'd4:    issue(v, '0, r[12:8], 1'b1, 1'b0, 1'b0, sz, 1'b1, r[13], '0, '0);
            3'd5:    issue(v, '0, r[12:8], 1'b0, 1'b0, 1'b0, sz, 1'b0, 1'b1, '0, '0);
            3'd6:    issue(v, '0, r[12:8], 1'b1, 1'b0, 1'b0, sz, 1'b0, 1'b0, r[17:16],
                           csr_we_t'(1 << r[15:14]));
            3'd7:    bubble();
            default: issue(v, '0, r[12:8], r[13], 1'b0, 1'b0, sz, 1'b0, 1'b0, '0, '0);
        endcase
    endtask

    task automatic check_regs();
        repeat (3) bubble(); // let the last write land.
        for (int i = 0; i < 32; i++) begin
            bubble();
            dbg_raddr = reg_idx_t'(i);
            rs_addr   = reg_idx_t'(31 - i);
            @(negedge clk);
            check_word($sformatf("dbg_rdata x%0d", i), dbg_rdata, m_regs[i], reg_errors);
            check_word($sformatf("rs_data x%0d", 31 - i), rs_data, m_regs[31 - i], reg_errors);
        end
    endtask

    // ##################################################
    // compare and timeout
    // ##################################################

    always begin
        @(posedge clk);
        if (rst_n) exp_q.push_back(cur_exp);
        @(negedge clk);
        if (exp_q.size() >= 2) begin
            head = exp_q.pop_front();
            check_bit("wb_we", wb_we, head.we, tap_errors);
            check_idx("wb_rd", wb_rd, head.rd, tap_errors);
            check_word("wb_value", wb_value, head.value, tap_errors);
            check_word("retire_pc", retire_pc, head.pc, tap_errors);
            check_bit("retire_branch", retire_branch, head.branch, tap_errors);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ##################################################
    // test sequence
    // ##################################################

    initial begin
        seed        = 6087;
        rst_n       = 1'b0;
        ex_result   = '0;
        store_data  = '0;
        pc          = '0;
        rd          = '0;
        r_wen       = 1'b0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_size    = size_byte;
        jump_flag   = 1'b0;
        branch_flag = 1'b0;
        csr_idx     = '0;
        csr_wen     = '0;
        rs_addr     = '0;
        dbg_raddr   = '0;
        cur_exp     = '0;
        pc_ctr      = 32'h0000_1000;
        m_regs      = '{default: '0};
        m_csr       = '{default: '0};
        m_ram       = '{default: '0};
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_bit("wb_we", wb_we, 1'b0, reg_errors);
        check_bit("retire_branch", retire_branch, 1'b0, reg_errors);
        check_regs();

        for (int w = 0; w < ram_words; w++) begin
            store(word_t'(w) << 2, (word_t'(w) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3, size_word);
        end

        alu(5'd1, 32'h1234_5678);
        alu(5'd2, 32'hffff_0000);
        alu(5'd0, 32'hdead_beef);  // x0 stays zero.
        alu(5'd31, 32'h0000_0031);
        bubble();
        issue(32'h5555_aaaa, '0, 5'd3, 1'b0, 1'b0, 1'b0, size_word, 1'b0, 1'b0, '0, '0);
        alu(5'd2, 32'h0bad_f00d);
        check_regs();

        store(32'h41, 32'hffff_ff80, size_byte);
        load(5'd4, 32'h41, size_byte);   // right behind the store.
        load(5'd5, 32'h41, size_byteu);
        load(5'd6, 32'h40, size_half);
        load(5'd7, 32'h40, size_halfu);
        load(5'd8, 32'h40, size_word);
        store(32'h46, 32'h1234_8001, size_half);
        load(5'd9, 32'h46, size_half);
        load(5'd10, 32'h46, size_halfu);
        load(5'd11, 32'h47, size_byte);
        load(5'd12, 32'h44, size_word);
        store(32'h48, 32'hdead_beef, size_word);
        load(5'd13, 32'h4b, size_byte);
        load(5'd14, 32'h4b, size_byteu);
        load(5'd15, 32'h4a, size_half);
        load(5'd16, 32'h48, size_halfu);
        load(5'd17, 32'h48, size_word);
        store(32'h4c, 32'h0000_7f7f, size_halfu);
        load(5'd18, 32'h4c, size_word);
        check_regs();

        issue(32'h0000_2000, '0, 5'd20, 1'b1, 1'b0, 1'b0, size_word, 1'b1, 1'b0, '0, '0);
        issue(32'h0000_3000, '0, 5'd0, 1'b0, 1'b0, 1'b0, size_word, 1'b0, 1'b1, '0, '0);
        issue(32'h50, '0, 5'd21, 1'b1, 1'b1, 1'b0, size_word, 1'b1, 1'b1, '0, '0);
        issue(32'h0000_4000, '0, 5'd0, 1'b1, 1'b0, 1'b0, size_word, 1'b1, 1'b0, '0, '0);
        check_regs();

        csr_access(5'd23, 2'd2, 32'haaaa_0001);
        csr_access(5'd24, 2'd2, 32'haaaa_0002); // bypassed old value.
        csr_access(5'd25, 2'd2, 32'haaaa_0003);
        csr_access(5'd26, 2'd0, 32'h0000_0c00);
        bubble();
        csr_access(5'd27, 2'd0, 32'h0000_0c01);
        csr_access(5'd28, 2'd3, 32'h3333_3333);
        issue(32'h54, '0, 5'd22, 1'b1, 1'b1, 1'b0, size_word, 1'b0, 1'b0, 2'd1, 4'b0010);
        csr_access(5'd29, 2'd1, 32'h1111_1111);
        check_regs();

        for (int n = 0; n < len_random; n++) begin
            random_instr();
        end
        check_regs();

        $display("errors: %0d on the writeback tap, %0d on register reads",
                 tap_errors, reg_errors);
        if (tap_errors == 0 && reg_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/backend_pkg.sv
source/data_ram.sv
source/mem_stage.sv
source/wb_unit.sv
source/reg_file.sv
source/csr_file.sv
source/backend_top.sv
bench/backend_tb.sv

// ==== Makefile ====
# verilator build, run, lint and clean for the rv32 back end

TOP := backend_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module backend_top

clean:
	rm -rf obj_dir
